// ==== hw/lz_pkg.sv ====
//----------------------------------------
// Shared LZ codec types and constants
// Length field is 5 bits, 0 encodes 32
//----------------------------------------
`default_nettype none

package lz_pkg;

  // Data and code word types
  typedef logic [7:0] byte_t;
  typedef logic [8:0] code_t;
  typedef logic [5:0] len_t;

  // Token layout
  localparam int FLAG_BIT = 8;
  localparam int LEN_W    = 5;
  localparam len_t MAX_RUN = 6'd32;

  // Code word source select
  localparam logic [1:0] SEL_OLDER = 2'd0;
  localparam logic [1:0] SEL_NEWER = 2'd1;
  localparam logic [1:0] SEL_LEN   = 2'd2;
  localparam logic [1:0] SEL_ADDR  = 2'd3;

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_WAIT_DEC,
    CS_OUT_LEN,
    CS_OUT_ADDR,
    CS_OUT_PEN,
    CS_OUT_LAST
  } coder_state_t;

  typedef enum logic [1:0] {
    DS_IDLE,
    DS_OUT_LIT,
    DS_OUT_HIST
  } dec_state_t;

endpackage

`default_nettype wire

// ==== hw/history_cam.sv ====
//----------------------------------------
// Shifting history, entry 0 is the newest
// Chain bits keep a fixed distance per run
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module history_cam #(
  parameter int HIST_DEPTH = 64,
  parameter int ADDR_W     = 6
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  lz_pkg::byte_t         din,
  input  logic                  ld,
  input  logic                  clr,
  input  logic [ADDR_W-1:0]     rd_addr,
  output logic [HIST_DEPTH-1:0] match_vec,
  output lz_pkg::byte_t         rd_data
);
  import lz_pkg::*;

  byte_t mem [HIST_DEPTH];
  logic [HIST_DEPTH-1:0] valid;
  logic [HIST_DEPTH-1:0] chain;
  logic [HIST_DEPTH-1:0] eq_vec;

  // Compare against every filled entry
  always_comb begin
    for (int i = 0; i < HIST_DEPTH; i++) begin
      eq_vec[i] = valid[i] && (mem[i] == din);
    end
  end

  assign match_vec = eq_vec & chain;
  assign rd_data   = mem[rd_addr];

  always_ff @(posedge clk) begin
    if (ld) begin
      mem[0] <= din;
      for (int i = 1; i < HIST_DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // clr with ld starts a fresh run on this byte
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid <= '0;
      chain <= '1;
    end else if (ld) begin
      valid <= {valid[HIST_DEPTH-2:0], 1'b1};
      chain <= clr ? eq_vec : match_vec;
    end else if (clr) begin
      chain <= '1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/match_prio_enc.sv ====
//----------------------------------------
// Lowest-index priority encoder, 16-way tree
// Input is zero padded to a power of 16
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module match_prio_enc #(
  parameter int HIST_DEPTH = 64,
  parameter int ADDR_W     = 6
) (
  input  logic [HIST_DEPTH-1:0] match_vec,
  output logic [ADDR_W-1:0]     addr,
  output logic                  hit
);

  localparam int LEVELS = (ADDR_W + 3) / 4;
  localparam int AW4    = 4 * LEVELS;
  localparam int PW     = 1 << AW4;

  logic [PW-1:0]  hv;
  logic [PW-1:0]  hv_nxt;
  logic [AW4-1:0] av     [PW];
  logic [AW4-1:0] av_nxt [PW];

  // {hit, index} of the lowest set bit of a group
  function automatic logic [4:0] pri16(input logic [15:0] v);
    logic [4:0] r;
    r = 5'd0;
    for (int k = 15; k >= 0; k--) begin
      if (v[k]) r = {1'b1, 4'(k)};
    end
    return r;
  endfunction

  always_comb begin
    int groups;
    logic [4:0] p;
    groups = 0;
    p = '0;
    hv = '0;
    hv[HIST_DEPTH-1:0] = match_vec;
    hv_nxt = '0;
    for (int i = 0; i < PW; i++) begin
      av[i] = '0;
      av_nxt[i] = '0;
    end
    // Each level folds 16 groups into one
    for (int lvl = 0; lvl < LEVELS; lvl++) begin
      groups = PW >> (4 * (lvl + 1));
      hv_nxt = '0;
      for (int g = 0; g < PW / 16; g++) begin
        if (g < groups) begin
          p = pri16(hv[g*16 +: 16]);
          hv_nxt[g] = p[4];
          av_nxt[g] = av[g*16 + p[3:0]] | (AW4'(p[3:0]) << (4 * lvl));
        end
      end
      hv = hv_nxt;
      for (int g = 0; g < PW / 16; g++) begin
        av[g] = av_nxt[g];
      end
    end
    hit  = hv[0];
    addr = av[0][ADDR_W-1:0];
  end

endmodule

`default_nettype wire

// ==== hw/coder_ctrl.sv ====
//----------------------------------------
// Coder FSM and run counter
// ld is only accepted in IDLE, file_in never with ld
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module coder_ctrl (
  input  logic         clk,
  input  logic         rstN,
  input  logic         ld,
  input  logic         file_in,
  input  logic         hit,
  input  logic         dec_busy,
  output lz_pkg::len_t run_len,
  output logic [1:0]   code_sel,
  output logic         code_valid,
  output logic         clr,
  output logic         busy
);
  import lz_pkg::*;

  coder_state_t state, next_state;
  coder_state_t new_st, tok_st;
  len_t cnt;
  logic tok_pair;
  logic tok_two;
  logic at_max;
  logic ld_end;
  logic fl_end;
  logic end_evt;

  // Run end events
  assign at_max  = (cnt == MAX_RUN);
  assign ld_end  = ld && (cnt != '0) && (!hit || at_max);
  assign fl_end  = file_in && !ld && (cnt != '0) && (state == CS_IDLE);
  assign end_evt = ld_end || fl_end;
  assign clr     = ld ? ((cnt == '0) || ld_end) : fl_end;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cnt <= '0;
    end else if (end_evt) begin
      cnt <= ld ? len_t'(1) : '0;
    end else if (ld) begin
      cnt <= cnt + len_t'(1);
    end
  end

  // Ended run is held here while the token goes out
  always_ff @(posedge clk) begin
    if (end_evt) run_len <= cnt;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tok_pair <= 1'b0;
      tok_two  <= 1'b0;
    end else if (end_evt) begin
      tok_pair <= (cnt >= len_t'(3));
      tok_two  <= (cnt == len_t'(2));
    end
  end

  always_comb begin
    if (cnt >= len_t'(3))      new_st = CS_OUT_LEN;
    else if (cnt == len_t'(2)) new_st = CS_OUT_PEN;
    else                       new_st = CS_OUT_LAST;
    if (tok_pair)      tok_st = CS_OUT_LEN;
    else if (tok_two)  tok_st = CS_OUT_PEN;
    else               tok_st = CS_OUT_LAST;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) state <= CS_IDLE;
    else       state <= next_state;
  end

  //----------------------------------------
  // Token output sequencing
  //----------------------------------------
  always_comb begin
    next_state = state;
    code_sel   = SEL_OLDER;
    code_valid = 1'b0;
    case (state)
      CS_IDLE: begin
        if (end_evt) next_state = dec_busy ? CS_WAIT_DEC : new_st;
      end
      CS_WAIT_DEC: begin
        if (!dec_busy) next_state = tok_st;
      end
      CS_OUT_LEN: begin
        code_sel   = SEL_LEN;
        code_valid = 1'b1;
        next_state = CS_OUT_ADDR;
      end
      CS_OUT_ADDR: begin
        code_sel   = SEL_ADDR;
        code_valid = 1'b1;
        next_state = CS_IDLE;
      end
      CS_OUT_PEN: begin
        code_sel   = SEL_OLDER;
        code_valid = 1'b1;
        next_state = CS_OUT_LAST;
      end
      CS_OUT_LAST: begin
        code_sel   = SEL_NEWER;
        code_valid = 1'b1;
        next_state = CS_IDLE;
      end
      default: next_state = CS_IDLE;
    endcase
  end

  // High in the token states and when the next cycle cannot take a byte
  assign busy = dec_busy || (state != CS_IDLE) || (next_state != CS_IDLE);

endmodule

`default_nettype wire

// ==== hw/coder.sv ====
//----------------------------------------
// Coder datapath, one code word per cycle
// History address is zero extended into 9 bits
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module coder #(
  parameter int HIST_DEPTH = 64,
  parameter int ADDR_W     = 6
) (
  input  logic          clk,
  input  logic          rstN,
  input  lz_pkg::byte_t din,
  input  logic          ld,
  input  logic          file_in,
  input  logic          dec_busy,
  output logic          busy,
  output lz_pkg::code_t code,
  output logic          code_valid
);
  import lz_pkg::*;

  logic [HIST_DEPTH-1:0] match_vec;
  logic [ADDR_W-1:0]     match_addr;
  logic [ADDR_W-1:0]     addr_q;
  logic                  hit;
  logic                  clr;
  logic [1:0]            code_sel;
  len_t                  run_len;
  byte_t                 din_d1, din_d2, din_d3;

  history_cam #(.HIST_DEPTH(HIST_DEPTH), .ADDR_W(ADDR_W)) u_cam (
    .clk, .rstN, .din, .ld, .clr,
    .rd_addr('0), .match_vec, .rd_data()
  );

  match_prio_enc #(.HIST_DEPTH(HIST_DEPTH), .ADDR_W(ADDR_W)) u_enc (
    .match_vec, .addr(match_addr), .hit
  );

  coder_ctrl u_ctrl (
    .clk, .rstN, .ld, .file_in, .hit, .dec_busy,
    .run_len, .code_sel, .code_valid, .clr, .busy
  );

  // Delay line also steps on a flush, so both pending literals sit at d3/d2
  always_ff @(posedge clk) begin
    if (ld || clr) begin
      din_d1 <= din;
      din_d2 <= din_d1;
      din_d3 <= din_d2;
    end
  end

  // Address of the surviving chain, frozen on the ending byte
  always_ff @(posedge clk) begin
    if (ld && hit && !clr) addr_q <= match_addr;
  end

  always_comb begin
    case (code_sel)
      SEL_OLDER: code = {1'b0, din_d3};
      SEL_NEWER: code = {1'b0, din_d2};
      SEL_LEN:   code = {1'b1, {(FLAG_BIT-LEN_W){1'b0}}, run_len[LEN_W-1:0]};
      default:   code = code_t'(addr_q);
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
//----------------------------------------
// Decoder with mirror history
// No new word is expected while dec_busy is high
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decoder #(
  parameter int HIST_DEPTH = 64,
  parameter int ADDR_W     = 6
) (
  input  logic          clk,
  input  logic          rstN,
  input  lz_pkg::code_t code,
  input  logic          code_valid,
  output logic          dec_busy,
  output lz_pkg::byte_t data,
  output logic          out_valid
);
  import lz_pkg::*;

  dec_state_t state, next_state;
  byte_t lit_q;
  byte_t hist_byte;
  len_t  len_cnt;
  logic [ADDR_W-1:0] addr_q;
  logic len_seen;
  logic lit_word;
  logic len_word;
  logic addr_word;
  logic last_byte;

  // Word classification
  assign lit_word  = code_valid && !len_seen && !code[FLAG_BIT];
  assign len_word  = code_valid && !len_seen && code[FLAG_BIT];
  assign addr_word = code_valid && len_seen;

  // Every output byte goes back into the history
  history_cam #(.HIST_DEPTH(HIST_DEPTH), .ADDR_W(ADDR_W)) u_hist (
    .clk, .rstN, .din(data), .ld(out_valid), .clr(1'b0),
    .rd_addr(addr_q), .match_vec(), .rd_data(hist_byte)
  );

  always_ff @(posedge clk) begin
    if (lit_word)  lit_q  <= code[7:0];
    if (addr_word) addr_q <= code[ADDR_W-1:0];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      len_seen <= 1'b0;
    end else if (len_word) begin
      len_seen <= 1'b1;
    end else if (addr_word) begin
      len_seen <= 1'b0;
    end
  end

  // Zero in the length field means a full run
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      len_cnt <= '0;
    end else if (len_word) begin
      len_cnt <= (code[LEN_W-1:0] == '0) ? MAX_RUN : len_t'(code[LEN_W-1:0]);
    end else if (state == DS_OUT_HIST) begin
      len_cnt <= len_cnt - len_t'(1);
    end
  end

  assign last_byte = (len_cnt == len_t'(1));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) state <= DS_IDLE;
    else       state <= next_state;
  end

  always_comb begin
    next_state = DS_IDLE;
    case (state)
      DS_OUT_HIST: begin
        if (!last_byte) next_state = DS_OUT_HIST;
      end
      default: begin
        if (lit_word)       next_state = DS_OUT_LIT;
        else if (addr_word) next_state = DS_OUT_HIST;
      end
    endcase
  end

  assign out_valid = (state != DS_IDLE);
  assign data      = (state == DS_OUT_HIST) ? hist_byte : lit_q;
  assign dec_busy  = len_seen || (state == DS_OUT_HIST);

endmodule

`default_nettype wire

// ==== hw/codec.sv ====
//----------------------------------------
// LZ codec top, coder feeding decoder
// Load only after a cycle with busy low
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module codec #(
  parameter int HIST_DEPTH = 64
) (
  input  logic          clk,
  input  logic          rstN,
  input  lz_pkg::byte_t din,
  input  logic          ld,
  input  logic          file_in,
  output logic          busy,
  output lz_pkg::byte_t data,
  output logic          out_valid,
  output lz_pkg::code_t code,
  output logic          code_valid
);

  localparam int ADDR_W = $clog2(HIST_DEPTH);

  // Decoder back-pressure
  logic dec_busy;

  coder #(.HIST_DEPTH(HIST_DEPTH), .ADDR_W(ADDR_W)) u_coder (
    .clk, .rstN, .din, .ld, .file_in, .dec_busy,
    .busy, .code, .code_valid
  );

  decoder #(.HIST_DEPTH(HIST_DEPTH), .ADDR_W(ADDR_W)) u_decoder (
    .clk, .rstN, .code, .code_valid,
    .dec_busy, .data, .out_valid
  );

endmodule

`default_nettype wire

// ==== tests/codec_tb.sv ====
//----------------------------------------
// Random round trip of the LZ codec
// Loads and flushes only after busy was low
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module codec_tb;
  import lz_pkg::*;

  localparam int HIST_DEPTH     = 64;
  localparam int RAND_FILES     = 10;
  localparam int ALT_FILES      = 6;
  localparam int BURST_FILES    = 4;
  localparam int MAX_FILE_LEN   = 40;
  localparam int LONG_LEN       = 70;
  localparam int MAX_BYTES      = (RAND_FILES + ALT_FILES + BURST_FILES) * MAX_FILE_LEN
                                  + LONG_LEN;
  localparam int TIMEOUT_CYCLES = MAX_BYTES * 40 + 200;

  // Byte sources for a file
  localparam int MODE_RAND = 0;
  localparam int MODE_ALT  = 1;
  localparam int MODE_SAME = 2;

  logic  clk;
  logic  rstN;
  byte_t din;
  logic  ld;
  logic  file_in;
  logic  busy;
  byte_t data;
  logic  out_valid;
  code_t code;
  logic  code_valid;

  byte_t       model_q[$];
  byte_t       loaded_q[$];
  byte_t       exp_byte;
  logic [31:0] lfsr          = 32'hb35ad89d;
  int          cycle_cnt     = 0;
  int          mismatch_errs = 0;
  int          other_errs    = 0;
  int          out_total     = 0;
  int          code_total    = 0;
  int          code_pos      = 0;
  int          tok_len       = 0;
  logic        addr_due      = 1'b0;

  codec #(.HIST_DEPTH(HIST_DEPTH)) codec_inst (
    .clk, .rstN, .din, .ld, .file_in,
    .busy, .data, .out_valid, .code, .code_valid
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic expect_low(input string name, input logic value);
    assert (value === 1'b0) else begin
      mismatch_errs++;
      $display("mismatch at %0t: %s = %b, expected 0", $time, name, value);
    end
  endtask

  task automatic check_idle_outputs();
    expect_low("busy", busy);
    expect_low("out_valid", out_valid);
    expect_low("code_valid", code_valid);
    assert (codec_inst.u_coder.u_ctrl.state == CS_IDLE &&
            codec_inst.u_decoder.state == DS_IDLE) else begin
      other_errs++;
      $display("a state machine is not idle around reset at %0t", $time);
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures, %0d bytes decoded",
             mismatch_errs, other_errs, out_total);
  endtask

  // A pair repeats bytes found addr + 1 places back
  task automatic check_copy(input int addr);
    int src;
    assert (tok_len >= 3 && addr < HIST_DEPTH && addr < code_pos &&
            code_pos + tok_len <= loaded_q.size()) else begin
      other_errs++;
      $display("match pair with length %0d and address %0d is out of range at %0t",
               tok_len, addr, $time);
    end
    for (int k = 0; k < tok_len; k++) begin
      src = code_pos + k - addr - 1;
      if (src >= 0 && code_pos + k < loaded_q.size()) begin
        assert (loaded_q[src] === loaded_q[code_pos + k]) else begin
          mismatch_errs++;
          $display("mismatch at %0t: code pair byte %0d = %02h, expected %02h",
                   $time, k, loaded_q[src], loaded_q[code_pos + k]);
        end
      end
    end
    code_pos += tok_len;
  endtask

  // Waits for a cycle with busy low, sometimes idles when not bursting
  task automatic load_byte(input byte_t b, input logic burst);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (!busy && (burst || rand_bits(2) != 0)) begin
        din <= b;
        ld  <= 1'b1;
        model_q.push_back(b);
        loaded_q.push_back(b);
        done = 1'b1;
      end else begin
        ld <= 1'b0;
      end
    end
  endtask

  //----------------------------------------
  // One file: load, flush, drain, check
  //----------------------------------------
  task automatic run_file(input int len, input int mode, input logic burst,
                          input int code_limit);
    int    out_start;
    int    code_start;
    byte_t sym_a;
    byte_t sym_b;
    byte_t b;
    logic  quiet;
    out_start  = out_total;
    code_start = code_total;
    sym_a = byte_t'(rand_bits(8));
    sym_b = byte_t'(rand_bits(8));
    for (int i = 0; i < len; i++) begin
      case (mode)
        MODE_RAND: b = byte_t'(rand_bits(8));
        MODE_ALT:  b = (rand_bits(1) != 0) ? sym_b : sym_a;
        default:   b = sym_a;
      endcase
      load_byte(b, burst);
    end
    @(posedge clk);
    ld <= 1'b0;
    while (busy) begin
      @(posedge clk);
    end
    file_in <= 1'b1;
    @(posedge clk);
    file_in <= 1'b0;
    // Quiet means no token in flight and no byte coming out
    quiet = 1'b0;
    while (!quiet) begin
      @(posedge clk);
      quiet = !busy && !code_valid && !out_valid;
    end
    assert (model_q.size() == 0) else begin
      other_errs++;
      $display("%0d loaded bytes never came out after the flush at %0t",
               model_q.size(), $time);
      model_q.delete();
    end
    assert (code_pos == loaded_q.size()) else begin
      other_errs++;
      $display("%0d loaded bytes had no code word after the flush at %0t",
               loaded_q.size() - code_pos, $time);
      code_pos = loaded_q.size();
    end
    assert (out_total - out_start == len) else begin
      mismatch_errs++;
      $display("mismatch at %0t: output count = %0d, expected %0d",
               $time, out_total - out_start, len);
    end
    if (code_limit > 0) begin
      assert (code_total - code_start < code_limit) else begin
        other_errs++;
        $display("file of %0d repeated bytes took %0d code words, not fewer than %0d",
                 len, code_total - code_start, code_limit);
      end
    end
  endtask

  // Code word monitor against the loaded bytes
  always @(posedge clk) begin
    if (rstN && code_valid) begin
      code_total++;
      if (addr_due) begin
        check_copy(int'(code));
        addr_due = 1'b0;
      end else if (code[FLAG_BIT]) begin
        tok_len  = (code[LEN_W-1:0] == '0) ? int'(MAX_RUN) : int'(code[LEN_W-1:0]);
        addr_due = 1'b1;
      end else begin
        assert (code_pos < loaded_q.size()) else begin
          other_errs++;
          $display("literal word %03h at %0t with no loaded byte left", code, $time);
        end
        if (code_pos < loaded_q.size()) begin
          assert (code[7:0] === loaded_q[code_pos]) else begin
            mismatch_errs++;
            $display("mismatch at %0t: code = %03h, expected %03h",
                     $time, code, {1'b0, loaded_q[code_pos]});
          end
        end
        code_pos++;
      end
    end else if (rstN && addr_due) begin
      other_errs++;
      $display("no address word right after a length word at %0t", $time);
      addr_due = 1'b0;
    end
  end

  // Output monitor against the model queue
  always @(posedge clk) begin
    if (rstN && out_valid) begin
      out_total++;
      assert (model_q.size() > 0) else begin
        other_errs++;
        $display("output byte %02h at %0t with no loaded byte left to match", data, $time);
      end
      if (model_q.size() > 0) begin
        exp_byte = model_q.pop_front();
        assert (data === exp_byte) else begin
          mismatch_errs++;
          $display("mismatch at %0t: data = %02h, expected %02h", $time, data, exp_byte);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d loaded bytes still pending",
               cycle_cnt, model_q.size());
      print_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    int len;
    rstN    = 1'b0;
    ld      = 1'b0;
    file_in = 1'b0;
    din     = '0;
    // First edge only settles the reset
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i > 0) check_idle_outputs();
    end
    rstN <= 1'b1;
    @(posedge clk);
    check_idle_outputs();

    for (int f = 0; f < RAND_FILES; f++) begin
      len = 1 + int'(rand_bits(6)) % MAX_FILE_LEN;
      run_file(len, MODE_RAND, 1'b0, 0);
    end
    for (int f = 0; f < ALT_FILES; f++) begin
      len = 1 + int'(rand_bits(6)) % MAX_FILE_LEN;
      run_file(len, MODE_ALT, 1'b0, 0);
    end
    // Long run crosses MAX_RUN twice
    run_file(LONG_LEN, MODE_SAME, 1'b0, LONG_LEN);
    for (int f = 0; f < BURST_FILES; f++) begin
      len = 1 + int'(rand_bits(6)) % MAX_FILE_LEN;
      run_file(len, (f % 2 == 0) ? MODE_ALT : MODE_RAND, 1'b1, 0);
    end

    print_counts();
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hw/lz_pkg.sv
hw/history_cam.sv
hw/match_prio_enc.sv
hw/coder_ctrl.sv
hw/coder.sv
hw/decoder.sv
hw/codec.sv
tests/codec_tb.sv

// ==== Bender.yml ====
package:
  name: lz_codec

sources:
  - hw/lz_pkg.sv
  - hw/history_cam.sv
  - hw/match_prio_enc.sv
  - hw/coder_ctrl.sv
  - hw/coder.sv
  - hw/decoder.sv
  - hw/codec.sv
  - target: test
    files:
      - tests/codec_tb.sv
